/* dv/apu_tb.sv */
// Expects in-order writeback with exactly one wb_we_o pulse per accepted real instruction
`timescale 1ns/1ns
`include "apu_defs.svh"

module apu_tb import apu_pkg::*; ();

  localparam int max_gap = 3;

  logic                clk_i;
  logic                rst_ni;
  logic [31:0]         instr_i;
  logic                instr_valid_i;
  logic                stall_o, active_o, wb_we_o, perf_type_o, perf_cont_o;
  logic [`APU_AW-1:0]  wb_waddr_o;
  logic [`APU_DW-1:0]  wb_data_o;

  // Stimulus table, one instruction word and idle gap per row
  logic [31:0]                   tab_word [$];
  int                            tab_gap [$];
  // Reference register array and pending results, program order
  logic [`APU_DW-1:0]            ref_regs [`APU_NREGS];
  logic [`APU_AW+`APU_DW-1:0]    exp_q [$];
  logic [31:0]                   lcg_state;
  int                            hang_limit;
  longint                        wd_ns;
  // Cycle counts of the status strobes
  int                            n_active, n_type, n_stall;
  // Rows that open an observation window, and counts at its start
  int                            row_type, row_active, row_div2;
  int                            base_type, base_active, base_stall;

  apu_top dut_i (.*);

  always #20 clk_i = ~clk_i;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc_r(input apu_op_e op, input int rd, rs1, rs2, rs3);
    apu_instr_u w;
    w       = '0;
    w.r.op  = op;
    w.r.rd  = rd[`APU_AW-1:0];
    w.r.rs1 = rs1[`APU_AW-1:0];
    w.r.rs2 = rs2[`APU_AW-1:0];
    w.r.rs3 = rs3[`APU_AW-1:0];
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input int rd, rs1, input logic [`APU_DW-1:0] imm);
    apu_instr_u w;
    w       = '0;
    w.i.op  = OP_ADDI;
    w.i.rd  = rd[`APU_AW-1:0];
    w.i.rs1 = rs1[`APU_AW-1:0];
    w.i.imm = imm;
    return w;
  endfunction

  // Architectural result, computed from the reference array
  function automatic logic [`APU_DW-1:0] predict(input apu_instr_u w);
    logic [`APU_DW-1:0] a, b, c, res;
    a = ref_regs[w.r.rs1];
    b = ref_regs[w.r.rs2];
    c = ref_regs[w.r.rs3];
    case (w.r.op)
      OP_ADD:  res = a + b;
      OP_ADDI: res = a + w.i.imm;
      OP_MAC:  res = a * b + c;
      OP_DIV:  res = (b == '0) ? '1 : a / b;
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic add_row(input logic [31:0] word, input int gap);
    tab_word.push_back(word);
    tab_gap.push_back(gap);
  endtask

  // Waits for a free slot, drives the word for one cycle and queues its result
  task automatic issue_row(input logic [31:0] word, input int gap);
    int                 waited;
    apu_instr_u         w;
    logic [`APU_DW-1:0] res;
    waited = 0;
    w      = word;
    while (stall_o) begin
      instr_valid_i = 1'b0;
      if (waited > hang_limit) begin
        fail_run("Decode stayed stalled too long, the instruction stream hung");
      end else begin
        @(negedge clk_i);
        waited++;
      end
    end
    instr_i       = word;
    instr_valid_i = 1'b1;
    res           = predict(w);
    exp_q.push_back({w.r.rd, res});
    // Register 0 never changes
    if (w.r.rd != '0) begin
      ref_regs[w.r.rd] = res;
    end
    @(negedge clk_i);
    if (gap > 0) begin
      instr_valid_i = 1'b0;
      repeat (gap) @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // Writeback monitor
  //////////////////////////////

  // Outputs settle after the falling edge, sampled at the rising one
  always @(posedge clk_i) begin
    if (rst_ni) begin
      n_active <= n_active + int'(active_o);
      n_type   <= n_type + int'(perf_type_o);
      n_stall  <= n_stall + int'(perf_type_o | perf_cont_o);
      if (wb_we_o) begin
        if (exp_q.size() == 0) begin
          fail_run("Writeback seen with no result pending");
        end else begin
          compare("wb_waddr_o", wb_waddr_o, exp_q[0][`APU_AW+`APU_DW-1:`APU_DW]);
          compare("wb_data_o", wb_data_o, exp_q[0][`APU_DW-1:0]);
          void'(exp_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int n;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    n_active      = 0;
    n_type        = 0;
    n_stall       = 0;
    base_type     = 0;
    base_active   = 0;
    base_stall    = 0;
    lcg_state     = 32'h3334_5d19;
    for (int i = 0; i < `APU_NREGS; i++) begin
      ref_regs[i] = '0;
    end

    // Operand preamble, some immediates random
    for (int r = 1; r <= 3; r++) begin
      lcg_state = next_rand(lcg_state);
      add_row(enc_i(r, 0, lcg_state[31:16]), 0);
    end
    add_row(enc_i(4, 0, 16'h0003), 1);
    add_row(enc_i(5, 0, 16'h0007), 0);
    add_row(enc_i(6, 0, 16'h1234), 2);
    // Sums, r0 as source and as dropped destination
    add_row(enc_r(OP_ADD, 10, 1, 2, 0), 0);
    add_row(enc_r(OP_ADD, 11, 0, 3, 0), 1);
    add_row(enc_i(12, 10, 16'hfff0), 0);
    add_row(enc_i(0, 1, 16'h0005), 0);
    add_row(enc_r(OP_ADD, 13, 0, 12, 0), 3);
    // Chained multiply-add
    add_row(enc_r(OP_MAC, 14, 4, 5, 1), 0);
    add_row(enc_r(OP_MAC, 15, 14, 4, 5), 0);
    add_row(enc_r(OP_MAC, 16, 15, 15, 14), 2);
    // Same-cycle add behind an outstanding MAC
    row_type = tab_word.size();
    add_row(enc_r(OP_MAC, 17, 2, 3, 4), 0);
    add_row(enc_r(OP_ADD, 18, 5, 6, 0), 1);
    // Divides with dependent adds, one by zero
    row_active = tab_word.size();
    add_row(enc_r(OP_DIV, 19, 6, 4, 0), 0);
    add_row(enc_r(OP_ADD, 20, 19, 5, 0), 0);
    add_row(enc_r(OP_DIV, 21, 6, 0, 0), 0);
    add_row(enc_r(OP_ADD, 22, 21, 4, 0), 2);
    // Back-to-back divides
    row_div2 = tab_word.size();
    add_row(enc_r(OP_DIV, 23, 1, 5, 0), 0);
    add_row(enc_r(OP_DIV, 24, 2, 4, 0), 0);
    add_row(enc_r(OP_ADD, 25, 23, 24, 0), 0);

    hang_limit = 2 * `APU_DIV_CYCLES * tab_word.size();
    wd_ns      = (longint'(tab_word.size()) * (`APU_DIV_CYCLES + max_gap + 4) + 16) * 40;

    // Watchdog
    fork
      begin
        #(wd_ns);
        fail_run("Watchdog expired before the run finished");
      end
    join_none

    // Reset, outputs must stay low throughout
    repeat (16) begin
      @(negedge clk_i);
      compare("stall_o", stall_o, 1'b0);
      compare("active_o", active_o, 1'b0);
      compare("wb_we_o", wb_we_o, 1'b0);
      compare("perf_type_o", perf_type_o, 1'b0);
      compare("perf_cont_o", perf_cont_o, 1'b0);
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare("stall_o", stall_o, 1'b0);
    compare("active_o", active_o, 1'b0);
    compare("wb_we_o", wb_we_o, 1'b0);
    compare("perf_type_o", perf_type_o, 1'b0);
    compare("perf_cont_o", perf_cont_o, 1'b0);

    for (int i = 0; i < tab_word.size(); i++) begin
      if (i == row_type) begin
        base_type = n_type;
      end
      if (i == row_active) begin
        base_active = n_active;
      end
      if (i == row_div2) begin
        base_stall = n_stall;
      end
      issue_row(tab_word[i], tab_gap[i]);
      // Each window closes one row after it opened
      if ((i == row_type + 1) && (n_type == base_type)) begin
        fail_run("ADD behind an outstanding MAC never raised perf_type_o");
      end
      if ((i == row_active + 1) && (n_active == base_active)) begin
        fail_run("active_o stayed low while the DIV was outstanding");
      end
      if ((i == row_div2 + 1) && (n_stall == base_stall)) begin
        fail_run("DIV behind another DIV raised no performance stall strobe");
      end
    end
    instr_valid_i = 1'b0;

    // Let outstanding results drain
    n = 0;
    while (exp_q.size() != 0 && n < hang_limit) begin
      @(negedge clk_i);
      n++;
    end
    repeat (2) @(negedge clk_i);

    if (exp_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run($sformatf("%0d results never written back", exp_q.size()));
    end
  end

endmodule

/* list.f */
+incdir+logic
logic/apu_pkg.sv
logic/apu_req_if.sv
logic/apu_decode.sv
logic/apu_disp.sv
logic/apu_unit.sv
logic/apu_regfile.sv
logic/apu_top.sv
dv/apu_tb.sv

/* logic/apu_decode.sv */
// Holds one instruction while stalled. Operands are reread every cycle, never stored
`timescale 1ns/1ns
`include "apu_defs.svh"

module apu_decode import apu_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  apu_instr_u          instr_i,
  input  logic                instr_valid_i,
  input  logic [`APU_DW-1:0]  rdata_a_i,
  input  logic [`APU_DW-1:0]  rdata_b_i,
  input  logic [`APU_DW-1:0]  rdata_c_i,
  input  logic                stall_i,
  input  logic                dep_i,
  output logic [`APU_AW-1:0]  raddr_a_o,
  output logic [`APU_AW-1:0]  raddr_b_o,
  output logic [`APU_AW-1:0]  raddr_c_o,
  output logic [2:0]          rvalid_o,
  output logic [`APU_AW-1:0]  waddr_o,
  output apu_lat_e            lat_o,
  output apu_op_e             op_o,
  output logic [`APU_DW-1:0]  opa_o,
  output logic [`APU_DW-1:0]  opb_o,
  output logic [`APU_DW-1:0]  opc_o,
  output logic                enable_o,
  output logic                is_decoding_o,
  output logic                accept_o
);

  apu_instr_u instr_q;
  apu_instr_u instr;
  logic       held_q;
  logic       instr_vld;
  logic       is_real;

  // Held word wins over the input port
  assign instr     = held_q ? instr_q : instr_i;
  assign instr_vld = held_q | instr_valid_i;

  // Latency class and used sources, bit 0 is rs1
  always_comb begin
    lat_o    = LAT_NONE;
    rvalid_o = 3'b000;
    case (instr.r.op)
      OP_ADD: begin
        lat_o    = LAT_ONE;
        rvalid_o = 3'b011;
      end
      OP_ADDI: begin
        lat_o    = LAT_ONE;
        rvalid_o = 3'b001;
      end
      OP_MAC: begin
        lat_o    = LAT_TWO;
        rvalid_o = 3'b111;
      end
      OP_DIV: begin
        lat_o    = LAT_MULTI;
        rvalid_o = 3'b011;
      end
      default: ;
    endcase
  end

  assign is_real       = (lat_o != LAT_NONE);
  assign op_o          = instr.r.op;
  assign waddr_o       = instr.r.rd;
  assign raddr_a_o     = instr.r.rs1;
  assign raddr_b_o     = instr.r.rs2;
  assign raddr_c_o     = instr.r.rs3;
  assign is_decoding_o = instr_vld;
  assign enable_o      = instr_vld & is_real & ~dep_i;
  assign accept_o      = ~held_q;

  // Unused sources read as zero, ADDI takes b from the immediate view
  assign opa_o = rvalid_o[0] ? rdata_a_i : '0;
  assign opb_o = (instr.i.op == OP_ADDI) ? instr.i.imm : (rvalid_o[1] ? rdata_b_i : '0);
  assign opc_o = rvalid_o[2] ? rdata_c_i : '0;

  // Keep the word until the dispatcher takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else begin
      held_q <= instr_vld & is_real & (stall_i | dep_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!held_q) begin
      instr_q <= instr_i;
    end
  end

endmodule

/* logic/apu_defs.svh */
// Slice sizes. The instruction layout in apu_pkg only fits 64 registers and 16-bit data
`ifndef APU_DEFS_SVH
`define APU_DEFS_SVH

//////////////////////////////
// Register file geometry
//////////////////////////////

// Architectural registers
`define APU_NREGS 64
// Register address width, log2 of APU_NREGS
`define APU_AW 6
// Data word width
`define APU_DW 16

// Divider iterations, must divide APU_DW evenly
`define APU_DIV_CYCLES 8

`endif

/* logic/apu_disp.sv */
// Two outstanding operations at most. A slot source is busy until the cycle after its return
`timescale 1ns/1ns
`include "apu_defs.svh"

module apu_disp import apu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enable_i,
  input  apu_lat_e                 lat_i,
  input  logic [`APU_AW-1:0]       waddr_i,
  input  logic                     is_decoding_i,
  input  logic [2:0][`APU_AW-1:0]  read_regs_i,
  input  logic [2:0]               read_regs_valid_i,
  input  logic [`APU_AW-1:0]       write_reg_i,
  input  logic                     write_reg_valid_i,
  input  apu_op_e                  op_i,
  input  logic [`APU_DW-1:0]       opa_i,
  input  logic [`APU_DW-1:0]       opb_i,
  input  logic [`APU_DW-1:0]       opc_i,
  output logic                     stall_o,
  output logic                     read_dep_o,
  output logic                     write_dep_o,
  output logic                     active_o,
  output logic                     perf_type_o,
  output logic                     perf_cont_o,
  apu_req_if.disp                  req
);

  logic [`APU_AW-1:0] addr_infl_q, addr_wait_q;
  logic [`APU_AW-1:0] addr_infl_d, addr_wait_d;
  logic               valid_infl_q, valid_wait_q;
  logic               valid_infl_d, valid_wait_d;
  logic               ret_req, ret_infl, ret_wait;
  logic               valid_req, req_accepted, active;
  apu_lat_e           lat_q;
  logic               rd_hit_infl, rd_hit_wait;
  logic               stall_full, stall_type, stall_nack;

  //////////////////////////////
  // Request
  //////////////////////////////

  // Nack stalls keep req up, the others drop it
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & req.gnt;

  assign req.req   = valid_req;
  assign req.op    = op_i;
  assign req.opa   = opa_i;
  assign req.opb   = opb_i;
  assign req.opc   = opc_i;
  assign req.waddr = waddr_i;

  // Which slot the return belongs to, oldest first
  assign ret_req  = valid_req & req.valid & ~valid_infl_q & ~valid_wait_q;
  assign ret_infl = valid_infl_q & req.valid & ~valid_wait_q;
  assign ret_wait = valid_wait_q & req.valid;

  // Slot update
  always_comb begin
    valid_infl_d = valid_infl_q;
    valid_wait_d = valid_wait_q;
    addr_infl_d  = addr_infl_q;
    addr_wait_d  = addr_wait_q;
    if (req_accepted && !ret_req) begin
      // New operation stays outstanding
      valid_infl_d = 1'b1;
      addr_infl_d  = waddr_i;
      // Older one shifts down unless it leaves now
      if ((valid_infl_q && !ret_infl) || ret_wait) begin
        valid_wait_d = 1'b1;
        addr_wait_d  = addr_infl_q;
      end
    end else if (ret_infl) begin
      valid_infl_d = 1'b0;
      valid_wait_d = 1'b0;
    end else if (ret_wait) begin
      valid_wait_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_infl_q <= 1'b0;
      valid_wait_q <= 1'b0;
      addr_infl_q  <= '0;
      addr_wait_q  <= '0;
      lat_q        <= LAT_NONE;
    end else begin
      valid_infl_q <= valid_infl_d;
      valid_wait_q <= valid_wait_d;
      addr_infl_q  <= addr_infl_d;
      addr_wait_q  <= addr_wait_d;
      // Class of the most recent request
      if (valid_req) begin
        lat_q <= lat_i;
      end
    end
  end

  assign active   = valid_infl_q | valid_wait_q;
  assign active_o = active;

  //////////////////////////////
  // Dependencies
  //////////////////////////////

  // Source hits against either slot address
  always_comb begin
    rd_hit_infl = 1'b0;
    rd_hit_wait = 1'b0;
    for (int i = 0; i < 3; i++) begin
      if (read_regs_valid_i[i] && (read_regs_i[i] == addr_infl_q)) begin
        rd_hit_infl = 1'b1;
      end
      if (read_regs_valid_i[i] && (read_regs_i[i] == addr_wait_q)) begin
        rd_hit_wait = 1'b1;
      end
    end
  end

  // Slots count until cleared, so a dependent read sees the written array
  assign read_dep_o  = is_decoding_i & ((rd_hit_infl & valid_infl_q) |
                                        (rd_hit_wait & valid_wait_q));
  assign write_dep_o = is_decoding_i & write_reg_valid_i &
                       (((write_reg_i == addr_infl_q) & valid_infl_q) |
                        ((write_reg_i == addr_wait_q) & valid_wait_q));

  //////////////////////////////
  // Stalls
  //////////////////////////////

  assign stall_full  = valid_infl_q & valid_wait_q;
  // A faster class would overtake the outstanding one
  assign stall_type  = enable_i & active & ((lat_i == LAT_ONE) | (lat_i == LAT_MULTI) |
                       ((lat_i == LAT_TWO) & (lat_q == LAT_MULTI)));
  assign stall_nack  = valid_req & ~req.gnt;
  assign stall_o     = stall_full | stall_type | stall_nack;
  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  // Unit returns only what was accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req.valid |-> (req_accepted | valid_infl_q | valid_wait_q))
    else $error("Return with nothing outstanding");

  // Waiting slot only fills behind an in-flight one
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_wait_q |-> valid_infl_q)
    else $error("Waiting slot valid without in-flight slot");

endmodule

/* logic/apu_pkg.sv */
// Opcode values are fixed by the instruction layout. Unknown opcodes decode as NOP
`include "apu_defs.svh"

package apu_pkg;

  // Operations of the slice
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_ADDI = 4'd2,
    OP_MAC  = 4'd3,
    OP_DIV  = 4'd4
  } apu_op_e;

  // Latency class, ordered by return time
  typedef enum logic [1:0] {
    LAT_NONE  = 2'd0,
    LAT_ONE   = 2'd1,
    LAT_TWO   = 2'd2,
    LAT_MULTI = 2'd3
  } apu_lat_e;

  // Instruction word, op sits in the top nibble of both views
  typedef union packed {
    struct packed {
      apu_op_e             op;
      logic [`APU_AW-1:0]  rd;
      logic [`APU_AW-1:0]  rs1;
      logic [`APU_AW-1:0]  rs2;
      logic [`APU_AW-1:0]  rs3;
      logic [27-4*`APU_AW:0] spare;
    } r;
    struct packed {
      apu_op_e             op;
      logic [`APU_AW-1:0]  rd;
      logic [`APU_AW-1:0]  rs1;
      logic [`APU_DW-1:0]  imm;
    } i;
  } apu_instr_u;

endpackage

/* logic/apu_regfile.sv */
// Register 0 is hardwired to zero. A write shows on the read ports from the next cycle on
`timescale 1ns/1ns
`include "apu_defs.svh"

module apu_regfile (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`APU_AW-1:0]  raddr_a_i,
  input  logic [`APU_AW-1:0]  raddr_b_i,
  input  logic [`APU_AW-1:0]  raddr_c_i,
  input  logic                we_i,
  input  logic [`APU_AW-1:0]  waddr_i,
  input  logic [`APU_DW-1:0]  wdata_i,
  output logic [`APU_DW-1:0]  rdata_a_o,
  output logic [`APU_DW-1:0]  rdata_b_o,
  output logic [`APU_DW-1:0]  rdata_c_o
);

  logic [`APU_DW-1:0] mem_q [`APU_NREGS];

  // One read port
  function automatic logic [`APU_DW-1:0] rd_port(input logic [`APU_AW-1:0] addr);
    return (addr == '0) ? '0 : mem_q[addr];
  endfunction

  always_comb begin
    rdata_a_o = rd_port(raddr_a_i);
    rdata_b_o = rd_port(raddr_b_i);
    rdata_c_o = rd_port(raddr_c_i);
  end

  // Array cleared on reset, writes to register 0 dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `APU_NREGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

endmodule

/* logic/apu_req_if.sv */
// One request per cycle when req and gnt are high. Returns come back in issue order
`timescale 1ns/1ns
`include "apu_defs.svh"

interface apu_req_if import apu_pkg::*; ();

  // Request channel
  logic                req;
  logic                gnt;
  apu_op_e             op;
  logic [`APU_DW-1:0]  opa;
  logic [`APU_DW-1:0]  opb;
  logic [`APU_DW-1:0]  opc;
  logic [`APU_AW-1:0]  waddr;

  // Return channel, one valid per accepted operation
  logic                valid;
  logic [`APU_DW-1:0]  rdata;
  logic [`APU_AW-1:0]  rwaddr;

  modport disp (output req, op, opa, opb, opc, waddr, input gnt, valid);
  modport unit (input req, op, opa, opb, opc, waddr, output gnt, valid, rdata, rwaddr);

endinterface

/* logic/apu_top.sv */
// New instructions are taken only while stall_o is low. Writeback is exposed for checking
`timescale 1ns/1ns
`include "apu_defs.svh"

module apu_top import apu_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [31:0]         instr_i,
  input  logic                instr_valid_i,
  output logic                stall_o,
  output logic                active_o,
  output logic                wb_we_o,
  output logic [`APU_AW-1:0]  wb_waddr_o,
  output logic [`APU_DW-1:0]  wb_data_o,
  output logic                perf_type_o,
  output logic                perf_cont_o
);

  apu_instr_u         instr;
  logic [`APU_AW-1:0] raddr_a, raddr_b, raddr_c, waddr;
  logic [`APU_DW-1:0] rdata_a, rdata_b, rdata_c, opa, opb, opc;
  logic [2:0]         rvalid;
  apu_lat_e           lat;
  apu_op_e            op;
  logic               enable, is_decoding, accept, disp_stall, read_dep, write_dep;

  apu_req_if req_if ();

  assign instr = instr_i;

  apu_decode u_decode (
    .clk_i, .rst_ni, .instr_i(instr), .instr_valid_i,
    .rdata_a_i(rdata_a), .rdata_b_i(rdata_b), .rdata_c_i(rdata_c),
    .stall_i(disp_stall), .dep_i(read_dep | write_dep),
    .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .raddr_c_o(raddr_c), .rvalid_o(rvalid),
    .waddr_o(waddr), .lat_o(lat), .op_o(op), .opa_o(opa), .opb_o(opb), .opc_o(opc),
    .enable_o(enable), .is_decoding_o(is_decoding), .accept_o(accept)
  );

  // Every real operation writes its rd
  apu_disp u_disp (
    .clk_i, .rst_ni, .enable_i(enable), .lat_i(lat), .waddr_i(waddr),
    .is_decoding_i(is_decoding), .read_regs_i({raddr_c, raddr_b, raddr_a}),
    .read_regs_valid_i(rvalid), .write_reg_i(waddr), .write_reg_valid_i(lat != LAT_NONE),
    .op_i(op), .opa_i(opa), .opb_i(opb), .opc_i(opc), .stall_o(disp_stall),
    .read_dep_o(read_dep), .write_dep_o(write_dep), .active_o, .perf_type_o, .perf_cont_o,
    .req(req_if.disp)
  );

  apu_unit u_unit (.clk_i, .rst_ni, .req(req_if.unit));

  // Write port straight from the unit return
  apu_regfile u_regfile (
    .clk_i, .rst_ni, .raddr_a_i(raddr_a), .raddr_b_i(raddr_b), .raddr_c_i(raddr_c),
    .we_i(req_if.valid), .waddr_i(req_if.rwaddr), .wdata_i(req_if.rdata),
    .rdata_a_o(rdata_a), .rdata_b_o(rdata_b), .rdata_c_o(rdata_c)
  );

  assign stall_o    = ~accept;
  assign wb_we_o    = req_if.valid;
  assign wb_waddr_o = req_if.rwaddr;
  assign wb_data_o  = req_if.rdata;

endmodule

/* logic/apu_unit.sv */
// Returns stay in issue order only because the dispatcher blocks faster classes while active
`timescale 1ns/1ns
`include "apu_defs.svh"

module apu_unit import apu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  apu_req_if.unit req
);

  localparam int unsigned div_steps = `APU_DW / `APU_DIV_CYCLES;
  localparam int unsigned cnt_w     = $clog2(`APU_DIV_CYCLES);

  logic               fire, one_ret, mac_start, div_start, div_last;
  logic [`APU_DW-1:0] add_sum, mac_sum;
  logic               gnt_q, mac_valid_q, div_busy_q, div_done_q;
  logic [cnt_w-1:0]   div_cnt_q;
  logic [`APU_DW-1:0] mac_res_q, div_quo_q, div_dvs_q, div_quo_d, div_dvs_w;
  logic [`APU_DW:0]   div_rem_q, div_rem_d;
  logic [`APU_AW-1:0] mac_waddr_q, div_waddr_q;

  assign fire      = req.req & req.gnt;
  assign one_ret   = fire & ((req.op == OP_ADD) | (req.op == OP_ADDI));
  assign mac_start = fire & (req.op == OP_MAC);
  assign div_start = fire & (req.op == OP_DIV);
  assign div_last  = div_busy_q & (div_cnt_q == cnt_w'(`APU_DIV_CYCLES - 1));

  // Truncated to the data width
  assign add_sum = req.opa + req.opb;
  assign mac_sum = req.opa * req.opb + req.opc;

  // Restoring divider, first step runs in the grant cycle
  always_comb begin
    div_rem_d = div_start ? '0 : div_rem_q;
    div_quo_d = div_start ? req.opa : div_quo_q;
    div_dvs_w = div_start ? req.opb : div_dvs_q;
    for (int s = 0; s < div_steps; s++) begin
      div_rem_d = {div_rem_d[`APU_DW-1:0], div_quo_d[`APU_DW-1]};
      div_quo_d = {div_quo_d[`APU_DW-2:0], 1'b0};
      // Zero divisor always subtracts, giving all ones
      if (div_rem_d >= {1'b0, div_dvs_w}) begin
        div_rem_d    = div_rem_d - {1'b0, div_dvs_w};
        div_quo_d[0] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q       <= 1'b0;
      mac_valid_q <= 1'b0;
      div_busy_q  <= 1'b0;
      div_done_q  <= 1'b0;
      div_cnt_q   <= '0;
    end else begin
      gnt_q       <= ~(div_start | (div_busy_q & ~div_last));
      mac_valid_q <= mac_start;
      div_busy_q  <= div_start | (div_busy_q & ~div_last);
      div_done_q  <= div_last;
      if (div_start) begin
        div_cnt_q <= cnt_w'(1);
      end else if (div_busy_q) begin
        div_cnt_q <= div_cnt_q + cnt_w'(1);
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (mac_start) begin
      mac_res_q   <= mac_sum;
      mac_waddr_q <= req.waddr;
    end
    if (div_start) begin
      div_dvs_q   <= req.opb;
      div_waddr_q <= req.waddr;
    end
    if (div_start || div_busy_q) begin
      div_rem_q <= div_rem_d;
      div_quo_q <= div_quo_d;
    end
  end

  // Registered returns are older than a same-cycle add
  assign req.gnt    = gnt_q;
  assign req.valid  = one_ret | mac_valid_q | div_done_q;
  assign req.rdata  = mac_valid_q ? mac_res_q : (div_done_q ? div_quo_q : add_sum);
  assign req.rwaddr = mac_valid_q ? mac_waddr_q : (div_done_q ? div_waddr_q : req.waddr);

  assert property (@(posedge clk_i) disable iff (!rst_ni) div_busy_q |-> !req.gnt)
    else $error("Grant while divider busy");

  // At most one return source per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({one_ret, mac_valid_q, div_done_q}))
    else $error("Colliding returns");

endmodule
